// ==== Makefile ====
TOP := tb_serial_bus

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TESTBENCH PASSED'

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== common/serial_bus_pkg.sv ====
package serial_bus_pkg;

    // Serial protocol moves one byte per transfer
    parameter int DATA_WIDTH   = 8;
    parameter int ADDR_WIDTH   = 8;
    parameter int OFFSET_WIDTH = ADDR_WIDTH - 1;
    parameter int CNT_WIDTH    = $clog2(DATA_WIDTH);

    // Host sees a flat address, slaves split off the select bit
    typedef union packed {
        logic [ADDR_WIDTH-1:0] flat;
        struct packed {
            logic                    slave_sel;
            logic [OFFSET_WIDTH-1:0] offset;
        } fields;
    } bus_addr_t;

    //////////////////////////////
    // Slave controller states
    //////////////////////////////

    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        WRITE_SHIFT = 3'd1,
        WRITE_EXEC  = 3'd2,
        READ_FETCH  = 3'd3,
        DATA_READY  = 3'd4,
        SERIAL_TX   = 3'd5,
        CLEANUP     = 3'd6
    } slave_state_t;

endpackage

// ==== master/bus_master.sv ====
`timescale 1ns/1ns

module bus_master import serial_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req,
    input  logic                  req_write,
    input  bus_addr_t             req_addr,
    input  logic [DATA_WIDTH-1:0] req_wdata,
    input  logic [1:0]            ready,
    input  logic [1:0]            slave_done,
    input  logic [1:0]            miso,
    output logic                  busy,
    output logic                  done,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  bus_valid,
    output logic                  bus_write,
    output bus_addr_t             bus_addr,
    output logic                  mosi
);

    localparam logic [2:0] M_IDLE       = 3'd0;
    localparam logic [2:0] M_SHIFT_OUT  = 3'd1;
    localparam logic [2:0] M_WAIT_READY = 3'd2;
    localparam logic [2:0] M_SHIFT_IN   = 3'd3;
    localparam logic [2:0] M_FINISH     = 3'd4;

    logic [2:0]            state;
    logic                  accept;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic [DATA_WIDTH-1:0] rx_q;
    logic [DATA_WIDTH-1:0] rx_next;
    logic [CNT_WIDTH-1:0]  count;
    logic                  cnt_last;
    logic                  cnt_en;
    logic                  cnt_clear;

    assign accept    = (state == M_IDLE) && req;
    assign cnt_en    = (state == M_SHIFT_OUT) || (state == M_SHIFT_IN);
    assign cnt_clear = (state == M_FINISH);

    bit_counter bit_counter_i (
        .clk      (clk),
        .rstn     (rstn),
        .clear    (cnt_clear),
        .count_en (cnt_en),
        .count    (count),
        .last     (cnt_last)
    );

    //////////////////////////////
    // Transfer sequencing
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= M_IDLE;
            bus_valid <= 1'b0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (req) begin
                        bus_valid <= 1'b1;
                        state     <= req_write ? M_SHIFT_OUT : M_WAIT_READY;
                    end
                end
                M_SHIFT_OUT: begin
                    if (cnt_last) begin
                        state <= M_WAIT_READY;
                    end
                end
                M_WAIT_READY: begin
                    if (|slave_done) begin
                        bus_valid <= 1'b0;
                        state     <= M_FINISH;
                    end else if (|ready) begin
                        state <= M_SHIFT_IN;
                    end
                end
                M_SHIFT_IN: begin
                    // Last read bit and slave done land together
                    if (|slave_done) begin
                        bus_valid <= 1'b0;
                        state     <= M_FINISH;
                    end else if (cnt_last) begin
                        state <= M_WAIT_READY;
                    end
                end
                default: begin
                    state <= M_IDLE;
                end
            endcase
        end
    end

    // LSB arrives first, so shift right
    assign rx_next = {|miso, rx_q[DATA_WIDTH-1:1]};

    always_ff @(posedge clk) begin
        if (accept) begin
            bus_addr  <= req_addr;
            bus_write <= req_write;
            wdata_q   <= req_wdata;
        end
        if (state == M_SHIFT_IN) begin
            rx_q <= rx_next;
            if (cnt_last) begin
                rdata <= rx_next;
            end
        end
    end

    assign busy = (state != M_IDLE);
    assign done = (state == M_FINISH);
    assign mosi = (state == M_SHIFT_OUT) ? wdata_q[count] : 1'b0;

    // Slaves decode the address over the whole transfer
    assert property (@(posedge clk) disable iff (!rstn)
        $past(bus_valid) && bus_valid |-> $stable(bus_addr))
        else $error("bus_master: bus_addr changed during transfer");

endmodule

// ==== slave/bit_counter.sv ====
`timescale 1ns/1ns

module bit_counter import serial_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 clear,
    input  logic                 count_en,
    output logic [CNT_WIDTH-1:0] count,
    output logic                 last
);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (count_en) begin
            count <= count + 1'b1;
        end
    end

    assign last = (count == CNT_WIDTH'(DATA_WIDTH - 1));

    // Controllers never clear and advance in one cycle
    assert property (@(posedge clk) disable iff (!rstn) !(clear && count_en))
        else $error("bit_counter: clear and count_en together");

endmodule

// ==== slave/bus_slave.sv ====
`timescale 1ns/1ns

module bus_slave import serial_bus_pkg::*; #(
    parameter bit SLAVE_ID = 1'b0
) (
    input  logic      clk,
    input  logic      rstn,
    input  logic      bus_valid,
    input  logic      bus_write,
    input  bus_addr_t bus_addr,
    input  logic      mosi,
    output logic      miso,
    output logic      ready,
    output logic      done
);

    logic                  cnt_clear;
    logic                  cnt_en;
    logic                  cnt_last;
    logic [CNT_WIDTH-1:0]  count;
    logic                  shift_in_en;
    logic                  load_out;
    logic                  shift_out_en;
    logic                  buf_clear;
    logic                  mem_we;
    logic                  mem_re;
    logic [DATA_WIDTH-1:0] wr_word;
    logic [DATA_WIDTH-1:0] rd_word;

    slave_ctrl #(
        .SLAVE_ID (SLAVE_ID)
    ) slave_ctrl_i (
        .clk          (clk),
        .rstn         (rstn),
        .bus_valid    (bus_valid),
        .bus_write    (bus_write),
        .bus_addr     (bus_addr),
        .cnt_last     (cnt_last),
        .cnt_clear    (cnt_clear),
        .cnt_en       (cnt_en),
        .shift_in_en  (shift_in_en),
        .load_out     (load_out),
        .shift_out_en (shift_out_en),
        .mem_we       (mem_we),
        .mem_re       (mem_re),
        .buf_clear    (buf_clear),
        .ready        (ready),
        .done         (done)
    );

    bit_counter bit_counter_i (
        .clk      (clk),
        .rstn     (rstn),
        .clear    (cnt_clear),
        .count_en (cnt_en),
        .count    (count),
        .last     (cnt_last)
    );

    slave_shifter slave_shifter_i (
        .clk          (clk),
        .rstn         (rstn),
        .mosi         (mosi),
        .shift_in_en  (shift_in_en),
        .load_out     (load_out),
        .shift_out_en (shift_out_en),
        .buf_clear    (buf_clear),
        .count        (count),
        .rd_word      (rd_word),
        .wr_word      (wr_word),
        .miso         (miso)
    );

    // Select bit is decoded in the controller, memory sees the offset only
    slave_mem slave_mem_i (
        .clk    (clk),
        .rstn   (rstn),
        .we     (mem_we),
        .re     (mem_re),
        .offset (bus_addr.fields.offset),
        .wdata  (wr_word),
        .rdata  (rd_word)
    );

endmodule

// ==== slave/slave_ctrl.sv ====
`timescale 1ns/1ns

module slave_ctrl import serial_bus_pkg::*; #(
    parameter bit SLAVE_ID = 1'b0
) (
    input  logic      clk,
    input  logic      rstn,
    input  logic      bus_valid,
    input  logic      bus_write,
    input  bus_addr_t bus_addr,
    input  logic      cnt_last,
    output logic      cnt_clear,
    output logic      cnt_en,
    output logic      shift_in_en,
    output logic      load_out,
    output logic      shift_out_en,
    output logic      mem_we,
    output logic      mem_re,
    output logic      buf_clear,
    output logic      ready,
    output logic      done
);

    slave_state_t state;
    slave_state_t state_next;
    logic         selected;
    logic         sel_wr;
    logic         sel_rd;
    logic         tx_drain;
    logic         tx_active;

    assign selected = bus_valid && (bus_addr.fields.slave_sel == SLAVE_ID);
    assign sel_wr   = (state == IDLE) && selected && bus_write;
    assign sel_rd   = (state == IDLE) && selected && !bus_write;

    //////////////////////////////
    // State register
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= IDLE;
            tx_drain <= 1'b0;
        end else begin
            state    <= state_next;
            // miso is registered, so TX holds one cycle past the last bit
            tx_drain <= (state == SERIAL_TX) && cnt_last;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (sel_wr) begin
                    state_next = WRITE_SHIFT;
                end else if (sel_rd) begin
                    state_next = READ_FETCH;
                end
            end
            WRITE_SHIFT: begin
                if (cnt_last) begin
                    state_next = WRITE_EXEC;
                end
            end
            WRITE_EXEC:  state_next = CLEANUP;
            READ_FETCH:  state_next = DATA_READY;
            DATA_READY:  state_next = SERIAL_TX;
            SERIAL_TX: begin
                if (tx_drain) begin
                    state_next = CLEANUP;
                end
            end
            default:     state_next = IDLE;
        endcase
    end

    assign tx_active = (state == DATA_READY) || ((state == SERIAL_TX) && !tx_drain);

    assign shift_in_en  = sel_wr || (state == WRITE_SHIFT);
    assign cnt_en       = shift_in_en || tx_active;
    assign cnt_clear    = (state == CLEANUP);
    assign buf_clear    = (state == CLEANUP);
    assign mem_re       = sel_rd;
    assign load_out     = (state == READ_FETCH);
    assign shift_out_en = tx_active;
    assign mem_we       = (state == WRITE_EXEC);
    assign ready        = (state == DATA_READY);
    assign done         = (state == WRITE_EXEC) || ((state == SERIAL_TX) && tx_drain);

    assert property (@(posedge clk) disable iff (!rstn) !(ready && done))
        else $error("slave_ctrl: ready and done together");

    // Store only after the full byte has been shifted in
    assert property (@(posedge clk) disable iff (!rstn)
        mem_we |-> state == WRITE_EXEC && $past(state) == WRITE_SHIFT && $past(cnt_last))
        else $error("slave_ctrl: memory write outside WRITE_EXEC");

endmodule

// ==== slave/slave_mem.sv ====
`timescale 1ns/1ns

module slave_mem import serial_bus_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    we,
    input  logic                    re,
    input  logic [OFFSET_WIDTH-1:0] offset,
    input  logic [DATA_WIDTH-1:0]   wdata,
    output logic [DATA_WIDTH-1:0]   rdata
);

    localparam int DEPTH = 2 ** OFFSET_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (we) begin
                mem[offset] <= wdata;
            end
            if (re) begin
                rdata <= mem[offset];
            end
        end
    end

endmodule

// ==== slave/slave_shifter.sv ====
`timescale 1ns/1ns

module slave_shifter import serial_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  mosi,
    input  logic                  shift_in_en,
    input  logic                  load_out,
    input  logic                  shift_out_en,
    input  logic                  buf_clear,
    input  logic [CNT_WIDTH-1:0]  count,
    input  logic [DATA_WIDTH-1:0] rd_word,
    output logic [DATA_WIDTH-1:0] wr_word,
    output logic                  miso
);

    logic [DATA_WIDTH-1:0] out_buf;

    always_ff @(posedge clk) begin
        if (buf_clear) begin
            wr_word <= '0;
            out_buf <= '0;
        end else begin
            if (shift_in_en) begin
                wr_word[count] <= mosi;
            end
            if (load_out) begin
                out_buf <= rd_word;
            end
        end
    end

    // Return wire stays low unless transmitting
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            miso <= 1'b0;
        end else begin
            miso <= shift_out_en ? out_buf[count] : 1'b0;
        end
    end

endmodule

// ==== src.f ====
common/serial_bus_pkg.sv
slave/bit_counter.sv
slave/slave_ctrl.sv
slave/slave_shifter.sv
slave/slave_mem.sv
slave/bus_slave.sv
master/bus_master.sv
verilog/serial_bus_top.sv
tb/tb_serial_bus.sv

// ==== tb/tb_serial_bus.sv ====
`timescale 1ns/1ns

module tb_serial_bus import serial_bus_pkg::*; ();

    localparam int XFER_CYCLES = 3 * DATA_WIDTH + 10;
    localparam int NUM_RANDOM  = 200;
    localparam int NUM_OPS     = NUM_RANDOM + 40;
    localparam int WATCHDOG_NS = NUM_OPS * XFER_CYCLES * 4 * 2;

    logic                  clk;
    logic                  rstn;
    logic                  req;
    logic                  req_write;
    bus_addr_t             req_addr;
    logic [DATA_WIDTH-1:0] req_wdata;
    logic                  busy;
    logic                  done;
    logic [DATA_WIDTH-1:0] rdata;

    logic [DATA_WIDTH-1:0] ref_mem [256];
    logic [31:0]           lcg_state;
    logic                  pend_read;
    logic [ADDR_WIDTH-1:0] pend_addr;
    logic [DATA_WIDTH-1:0] pend_exp;
    logic                  done_q;
    int                    check_count;
    int                    mismatch_count;
    int                    fail_count;

    serial_bus_top serial_bus_top_i (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [7:0] random_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // Memory contents as seen through the flat address
    function automatic logic [DATA_WIDTH-1:0] expected_read(input logic [ADDR_WIDTH-1:0] addr);
        return ref_mem[addr];
    endfunction

    task automatic run_transfer(input logic wr, input logic [ADDR_WIDTH-1:0] addr,
                                input logic [DATA_WIDTH-1:0] wdata);
        int wait_cycles;
        wait_cycles = 0;
        @(negedge clk);
        pend_read = !wr;
        pend_addr = addr;
        pend_exp  = expected_read(addr);
        if (wr) begin
            ref_mem[addr] = wdata;
        end
        req           = 1'b1;
        req_write     = wr;
        req_addr.flat = addr;
        req_wdata     = wdata;
        @(negedge clk);
        req = 1'b0;
        assert (busy) else begin
            $display("busy did not rise after request to address %h", addr);
            fail_count++;
        end
        while (!done && wait_cycles < XFER_CYCLES) begin
            @(negedge clk);
            wait_cycles++;
        end
        assert (done) else begin
            $display("no done within %0d cycles for address %h", XFER_CYCLES, addr);
            fail_count++;
        end
    endtask

    // Second request arrives while the first write is still in flight
    task automatic req_while_busy(input logic [ADDR_WIDTH-1:0] addr,
                                  input logic [DATA_WIDTH-1:0] data,
                                  input logic [ADDR_WIDTH-1:0] extra_addr);
        int done_seen;
        done_seen = 0;
        @(negedge clk);
        pend_read     = 1'b0;
        ref_mem[addr] = data;
        req           = 1'b1;
        req_write     = 1'b1;
        req_addr.flat = addr;
        req_wdata     = data;
        for (int i = 0; i < XFER_CYCLES; i++) begin
            @(negedge clk);
            req = 1'b0;
            if (done) begin
                done_seen++;
            end
            if (i == 1) begin
                assert (busy) else begin
                    $display("busy low while the first write should be in flight");
                    fail_count++;
                end
                req           = 1'b1;
                req_addr.flat = extra_addr;
                req_wdata     = ~data;
            end
        end
        assert (done_seen == 1 && !busy) else begin
            $display("expected one done and idle bus after busy request, saw %0d", done_seen);
            fail_count++;
        end
    endtask

    //////////////////////////////
    // Response checker
    //////////////////////////////

    always @(negedge clk) begin
        if (!rstn) begin
            done_q = 1'b0;
        end else begin
            if (done_q) begin
                assert (!done && !busy) else begin
                    $display("done longer than one cycle or busy high after done");
                    fail_count++;
                end
            end
            if (done && pend_read) begin
                check_count++;
                assert (rdata === pend_exp) else begin
                    $display("mismatch rdata at addr %h: got %h, expected %h",
                             pend_addr, rdata, pend_exp);
                    mismatch_count++;
                end
            end
            done_q = done;
        end
    end

    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired after %0d ns with transfers still pending", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [7:0]            rnd;
        logic [7:0]            data;
        logic [ADDR_WIDTH-1:0] addr;
        logic [ADDR_WIDTH-1:0] last_wr_addr;
        rstn           = 1'b0;
        req            = 1'b0;
        req_write      = 1'b0;
        req_addr       = '0;
        req_wdata      = '0;
        pend_read      = 1'b0;
        pend_addr      = '0;
        pend_exp       = '0;
        check_count    = 0;
        mismatch_count = 0;
        fail_count     = 0;
        last_wr_addr   = '0;
        lcg_state      = 32'd37;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = '0;
        end
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        assert (!busy && !done) else begin
            $display("busy or done high after reset");
            fail_count++;
        end

        // Cleared memory at the edges and a few random spots
        run_transfer(1'b0, 8'h00, 8'h00);
        run_transfer(1'b0, 8'h7f, 8'h00);
        run_transfer(1'b0, 8'h80, 8'h00);
        run_transfer(1'b0, 8'hff, 8'h00);
        repeat (4) begin
            run_transfer(1'b0, random_byte(), 8'h00);
        end

        // Write then read back in both slaves
        foreach (ref_mem[i]) begin
            if (i == 'h05 || i == 'h42 || i == 'h85 || i == 'hc2) begin
                data = random_byte();
                run_transfer(1'b1, 8'(i), data);
                run_transfer(1'b0, 8'(i), 8'h00);
            end
        end

        // Same offset in each slave
        rnd  = random_byte();
        data = random_byte();
        run_transfer(1'b1, {1'b0, rnd[6:0]}, data);
        run_transfer(1'b1, {1'b1, rnd[6:0]}, ~data);
        run_transfer(1'b0, {1'b0, rnd[6:0]}, 8'h00);
        run_transfer(1'b0, {1'b1, rnd[6:0]}, 8'h00);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd  = random_byte();
            addr = random_byte();
            data = random_byte();
            if (rnd[3]) begin
                addr = last_wr_addr;
            end
            if (rnd[7]) begin
                last_wr_addr = addr;
            end
            run_transfer(rnd[7], addr, data);
        end

        req_while_busy(8'h10, random_byte(), 8'h90);
        run_transfer(1'b0, 8'h10, 8'h00);
        run_transfer(1'b0, 8'h90, 8'h00);

        repeat (2) @(negedge clk);
        $display("reads checked %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/serial_bus_top.sv ====
`timescale 1ns/1ns

module serial_bus_top import serial_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req,
    input  logic                  req_write,
    input  bus_addr_t             req_addr,
    input  logic [DATA_WIDTH-1:0] req_wdata,
    output logic                  busy,
    output logic                  done,
    output logic [DATA_WIDTH-1:0] rdata
);

    logic      bus_valid;
    logic      bus_write;
    bus_addr_t bus_addr;
    logic      mosi;
    logic [1:0] miso;
    logic [1:0] ready;
    logic [1:0] slave_done;

    bus_master bus_master_i (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .ready      (ready),
        .slave_done (slave_done),
        .miso       (miso),
        .busy       (busy),
        .done       (done),
        .rdata      (rdata),
        .bus_valid  (bus_valid),
        .bus_write  (bus_write),
        .bus_addr   (bus_addr),
        .mosi       (mosi)
    );

    // Lower half of the address space
    bus_slave #(
        .SLAVE_ID (1'b0)
    ) bus_slave0_i (
        .clk       (clk),
        .rstn      (rstn),
        .bus_valid (bus_valid),
        .bus_write (bus_write),
        .bus_addr  (bus_addr),
        .mosi      (mosi),
        .miso      (miso[0]),
        .ready     (ready[0]),
        .done      (slave_done[0])
    );

    // Upper half
    bus_slave #(
        .SLAVE_ID (1'b1)
    ) bus_slave1_i (
        .clk       (clk),
        .rstn      (rstn),
        .bus_valid (bus_valid),
        .bus_write (bus_write),
        .bus_addr  (bus_addr),
        .mosi      (mosi),
        .miso      (miso[1]),
        .ready     (ready[1]),
        .done      (slave_done[1])
    );

endmodule
